/* design/rob_consts.svh */
// sizing constants for the reorder buffer, included by the package and every RTL file
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

//------------------------------------------------------------
// buffer geometry
//------------------------------------------------------------
`define ROB_DEPTH    32  // number of entries
`define ROB_IDX_W    5   // entry index, the pointer adds a wrap bit on top

//------------------------------------------------------------
// field widths
//------------------------------------------------------------
`define PRF_IDX_W    6   // physical tag
`define ARCH_IDX_W   5   // logical register
`define FL_HEAD_W    5   // free-list head
`define BR_MASK_W    4   // branch mask
`define ADDR_W       64  // pc and branch target

// next pc increment
`define INSTR_BYTES  4

// tags and logical dests go back to this on reset and on retire
`define NULL_TAG     31

`endif

/* design/rob_pkg.sv */
// shared vector types and packed structs for the reorder buffer modules and testbench
`include "rob_consts.svh"

package rob_pkg;

	//------------------------------------------------------------
	// vector types
	//------------------------------------------------------------
	typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;   // entry index
	typedef logic [`ROB_IDX_W:0]    rob_ptr_t;   // index plus wrap bit
	typedef logic [`PRF_IDX_W-1:0]  prf_tag_t;
	typedef logic [`ARCH_IDX_W-1:0] arch_reg_t;
	typedef logic [`FL_HEAD_W-1:0]  fl_head_t;
	typedef logic [`BR_MASK_W-1:0]  br_mask_t;
	typedef logic [`ADDR_W-1:0]     addr_t;

	//------------------------------------------------------------
	// structs
	//------------------------------------------------------------
	// one entry as written at dispatch, also the stored layout
	typedef struct packed {
		prf_tag_t  new_tag;      // from the free list
		prf_tag_t  old_tag;      // from the map table
		arch_reg_t arch_dest;
		addr_t     pc;
		logic      br_flag;
		logic      pred_taken;
		addr_t     pred_target;
		br_mask_t  br_mask;
		fl_head_t  fl_head;      // free-list head at dispatch
		logic      halt;
	} rob_dispatch_t;

	typedef struct packed {
		rob_ptr_t ptr;           // entry of the branch
		logic     taken;         // actual direction
		addr_t    target;        // actual target
	} rob_resolve_t;

	typedef struct packed {
		prf_tag_t  arch_tag;     // to the architectural map
		prf_tag_t  old_tag;      // back to the free list
		arch_reg_t arch_dest;
	} rob_retire_t;

	typedef struct packed {
		br_mask_t br_mask;
		fl_head_t fl_head;
	} rob_recover_t;

endpackage

/* design/rob_ptr_ctrl.sv */
// head and tail pointer control for the reorder buffer, with full, empty, stall and rollback
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_ptr_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic              dispatch_en_i,   // allocate at tail
	input  logic              retire_rdy_i,    // head retires this cycle
	input  logic              recovery_i,      // mispredict, roll tail back
	input  rob_pkg::rob_ptr_t recover_ptr_i,   // pointer of the mispredicted branch
	output rob_pkg::rob_ptr_t head_o,
	output rob_pkg::rob_ptr_t tail_o,
	output logic              empty_o,
	output logic              stall_o
);

	rob_pkg::rob_ptr_t head_r;
	rob_pkg::rob_ptr_t tail_r;
	rob_pkg::rob_ptr_t head_nxt;
	rob_pkg::rob_ptr_t tail_nxt;
	logic              same_idx;
	logic              full;

	//------------------------------------------------------------
	// occupancy
	//------------------------------------------------------------
	assign same_idx = head_r[`ROB_IDX_W-1:0] == tail_r[`ROB_IDX_W-1:0];
	assign empty_o  = same_idx && (head_r[`ROB_IDX_W] == tail_r[`ROB_IDX_W]);
	assign full     = same_idx && (head_r[`ROB_IDX_W] != tail_r[`ROB_IDX_W]);

	// a retiring head frees a slot in the same cycle
	assign stall_o = full && !retire_rdy_i;

	//------------------------------------------------------------
	// next pointers
	//------------------------------------------------------------
	always_comb begin
		head_nxt = head_r;
		if (retire_rdy_i) begin
			head_nxt = head_r + 1'b1;
		end
	end

	always_comb begin
		tail_nxt = tail_r;
		if (recovery_i) begin
			// squash everything younger than the branch
			tail_nxt = recover_ptr_i + 1'b1;
		end else if (dispatch_en_i) begin
			tail_nxt = tail_r + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			head_r <= head_nxt;
			tail_r <= tail_nxt;
		end
	end

	assign head_o = head_r;
	assign tail_o = tail_r;

endmodule

/* design/rob_entry_store.sv */
// entry storage of the reorder buffer: tail write, done marking, head clear and read ports
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_entry_store (
	input  logic                   clk,
	input  logic                   rst,
	input  rob_pkg::rob_ptr_t      head_i,
	input  rob_pkg::rob_ptr_t      tail_i,
	// dispatch write
	input  logic                   dispatch_en_i,
	input  rob_pkg::rob_dispatch_t dispatch_i,
	// completion from the functional units
	input  logic                   complete_i,
	input  rob_pkg::rob_ptr_t      complete_idx_i,
	input  logic                   retire_rdy_i,
	// head read port
	output logic                   head_done_o,
	output logic                   head_halt_o,
	output rob_pkg::rob_retire_t   head_entry_o,
	// resolve read port
	input  rob_pkg::rob_ptr_t      res_idx_i,
	output logic                   res_br_flag_o,
	output logic                   res_pred_taken_o,
	output rob_pkg::addr_t         res_pred_target_o,
	output rob_pkg::rob_recover_t  res_recover_o,
	// next pc read port
	input  rob_pkg::rob_ptr_t      npc_rd_idx_i,
	output rob_pkg::addr_t         npc_o
);

	rob_pkg::rob_dispatch_t entry_r [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0]  done_r;
	rob_pkg::rob_dispatch_t clr_entry;

	rob_pkg::rob_idx_t head_idx;
	rob_pkg::rob_idx_t tail_idx;
	rob_pkg::rob_idx_t cmp_idx;
	rob_pkg::rob_idx_t res_idx;
	rob_pkg::rob_idx_t npc_idx;

	// wrap bits are dropped for addressing
	assign head_idx = head_i[`ROB_IDX_W-1:0];
	assign tail_idx = tail_i[`ROB_IDX_W-1:0];
	assign cmp_idx  = complete_idx_i[`ROB_IDX_W-1:0];
	assign res_idx  = res_idx_i[`ROB_IDX_W-1:0];
	assign npc_idx  = npc_rd_idx_i[`ROB_IDX_W-1:0];

	// empty slot contents: null tags, everything else zero
	always_comb begin
		clr_entry           = '0;
		clr_entry.new_tag   = rob_pkg::prf_tag_t'(`NULL_TAG);
		clr_entry.old_tag   = rob_pkg::prf_tag_t'(`NULL_TAG);
		clr_entry.arch_dest = rob_pkg::arch_reg_t'(`NULL_TAG);
	end

	//------------------------------------------------------------
	// writes, later assignments win on a shared index
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				entry_r[i] <= clr_entry;
			end
			done_r <= '0;
		end else begin
			if (retire_rdy_i) begin
				entry_r[head_idx] <= clr_entry;
				done_r[head_idx]  <= 1'b0;
			end
			if (dispatch_en_i) begin
				entry_r[tail_idx] <= dispatch_i;
				done_r[tail_idx]  <= 1'b0;   // not executed yet
			end
			if (complete_i) begin
				done_r[cmp_idx] <= 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// head port
	//------------------------------------------------------------
	assign head_done_o            = done_r[head_idx];
	assign head_halt_o            = entry_r[head_idx].halt;
	assign head_entry_o.arch_tag  = entry_r[head_idx].new_tag;
	assign head_entry_o.old_tag   = entry_r[head_idx].old_tag;
	assign head_entry_o.arch_dest = entry_r[head_idx].arch_dest;

	//------------------------------------------------------------
	// resolve port
	//------------------------------------------------------------
	assign res_br_flag_o         = entry_r[res_idx].br_flag;
	assign res_pred_taken_o      = entry_r[res_idx].pred_taken;
	assign res_pred_target_o     = entry_r[res_idx].pred_target;
	assign res_recover_o.br_mask = entry_r[res_idx].br_mask;   // mask to restore
	assign res_recover_o.fl_head = entry_r[res_idx].fl_head;   // free-list head to restore

	// fall-through pc for the branch unit
	assign npc_o = entry_r[npc_idx].pc + rob_pkg::addr_t'(`INSTR_BYTES);

endmodule

/* design/rob_branch_check.sv */
// branch outcome check against the stored prediction, with a one-cycle recovery pulse
`timescale 1ns/1ps

module rob_branch_check (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  resolve_done_i,   // branch unit result valid
	input  rob_pkg::rob_resolve_t resolve_i,
	input  logic                  br_flag_i,        // stored fields of the resolved entry
	input  logic                  pred_taken_i,
	input  rob_pkg::addr_t        pred_target_i,
	output logic                  recovery_o,
	output logic                  br_right_o
);

	logic block_r;      // set for the cycle after a recovery pulse
	logic br_valid;
	logic mispredict;

	assign br_valid = resolve_done_i && br_flag_i;

	// direction or target disagree
	assign mispredict = (pred_taken_i != resolve_i.taken) ||
	                    (pred_target_i != resolve_i.target);

	assign recovery_o = br_valid && mispredict && !block_r;
	assign br_right_o = br_valid && !mispredict;

	//------------------------------------------------------------
	// block bit
	//------------------------------------------------------------
	// a resolve held for a second cycle must not recover twice
	always_ff @(posedge clk) begin
		if (rst) begin
			block_r <= 1'b0;
		end else begin
			block_r <= recovery_o;
		end
	end

endmodule

/* design/rob_retire.sv */
// in-order retire decision at the head and the gated outputs to free list and arch map
`timescale 1ns/1ps

module rob_retire (
	input  logic                 head_done_i,    // head entry has executed
	input  logic                 empty_i,
	input  logic                 head_halt_i,
	input  rob_pkg::rob_retire_t head_entry_i,
	output logic                 retire_rdy_o,
	output logic                 halt_o,
	output rob_pkg::rob_retire_t retire_o
);

	// a stale done bit on an empty head must not retire
	assign retire_rdy_o = head_done_i && !empty_i;

	//------------------------------------------------------------
	// outputs
	//------------------------------------------------------------
	always_comb begin
		retire_o = '0;
		if (retire_rdy_o) begin
			retire_o = head_entry_i;   // tags and dest only when retiring
		end
	end

	// halt is seen as soon as it reaches the head, done or not
	assign halt_o = head_halt_i && !empty_i;

endmodule

/* design/rob_top.sv */
// reorder buffer top level, connects pointer control, entry store, branch check and retire
`timescale 1ns/1ps

module rob_top (
	input  logic                   clk,
	input  logic                   rst,
	// dispatch
	input  logic                   dispatch_en_i,
	input  rob_pkg::rob_dispatch_t dispatch_i,
	// completion
	input  logic                   complete_i,
	input  rob_pkg::rob_ptr_t      complete_idx_i,
	// branch unit
	input  logic                   resolve_done_i,
	input  rob_pkg::rob_resolve_t  resolve_i,
	input  rob_pkg::rob_ptr_t      npc_rd_idx_i,
	output rob_pkg::rob_ptr_t      tail_o,          // to the reservation stations
	output logic                   stall_o,
	// retire
	output logic                   retire_rdy_o,
	output rob_pkg::rob_retire_t   retire_o,
	output logic                   halt_o,
	// early recovery
	output logic                   recovery_o,
	output rob_pkg::rob_recover_t  recover_o,
	output logic                   br_right_o,
	output rob_pkg::addr_t         npc_o
);

	rob_pkg::rob_ptr_t    head;
	logic                 empty;
	logic                 head_done;
	logic                 head_halt;
	rob_pkg::rob_retire_t head_entry;
	logic                 res_br_flag;
	logic                 res_pred_taken;
	rob_pkg::addr_t       res_pred_target;

	//------------------------------------------------------------
	// pointers
	//------------------------------------------------------------
	rob_ptr_ctrl u_ptr_ctrl (
		.clk           (clk),
		.rst           (rst),
		.dispatch_en_i (dispatch_en_i),
		.retire_rdy_i  (retire_rdy_o),
		.recovery_i    (recovery_o),
		.recover_ptr_i (resolve_i.ptr),
		.head_o        (head),
		.tail_o        (tail_o),
		.empty_o       (empty),
		.stall_o       (stall_o)
	);

	rob_entry_store u_entry_store (
		.clk               (clk),
		.rst               (rst),
		.head_i            (head),
		.tail_i            (tail_o),
		.dispatch_en_i     (dispatch_en_i),
		.dispatch_i        (dispatch_i),
		.complete_i        (complete_i),
		.complete_idx_i    (complete_idx_i),
		.retire_rdy_i      (retire_rdy_o),
		.head_done_o       (head_done),
		.head_halt_o       (head_halt),
		.head_entry_o      (head_entry),
		.res_idx_i         (resolve_i.ptr),
		.res_br_flag_o     (res_br_flag),
		.res_pred_taken_o  (res_pred_taken),
		.res_pred_target_o (res_pred_target),
		.res_recover_o     (recover_o),
		.npc_rd_idx_i      (npc_rd_idx_i),
		.npc_o             (npc_o)
	);

	rob_branch_check u_branch_check (
		.clk            (clk),
		.rst            (rst),
		.resolve_done_i (resolve_done_i),
		.resolve_i      (resolve_i),
		.br_flag_i      (res_br_flag),
		.pred_taken_i   (res_pred_taken),
		.pred_target_i  (res_pred_target),
		.recovery_o     (recovery_o),
		.br_right_o     (br_right_o)
	);

	rob_retire u_retire (
		.head_done_i  (head_done),
		.empty_i      (empty),
		.head_halt_i  (head_halt),
		.head_entry_i (head_entry),
		.retire_rdy_o (retire_rdy_o),
		.halt_o       (halt_o),
		.retire_o     (retire_o)
	);

endmodule

/* tb/rob_tb.sv */
// directed testbench for the reorder buffer that run_sim.sh compiles with rob.f and runs
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_tb;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS  = 6;
	localparam int SEED       = 81444;

	logic                   clk;
	logic                   rst;
	logic                   dispatch_en_i;
	rob_pkg::rob_dispatch_t dispatch_i;
	logic                   complete_i;
	rob_pkg::rob_ptr_t      complete_idx_i;
	logic                   resolve_done_i;
	rob_pkg::rob_resolve_t  resolve_i;
	rob_pkg::rob_ptr_t      npc_rd_idx_i;
	rob_pkg::rob_ptr_t      tail_o;
	logic                   stall_o;
	logic                   retire_rdy_o;
	rob_pkg::rob_retire_t   retire_o;
	logic                   halt_o;
	logic                   recovery_o;
	rob_pkg::rob_recover_t  recover_o;
	logic                   br_right_o;
	rob_pkg::addr_t         npc_o;

	rob_pkg::rob_dispatch_t model_q [$];   // live entries with the oldest first
	rob_pkg::rob_ptr_t      ptr_q [$];     // pointer of each live entry
	rob_pkg::rob_ptr_t      exp_tail;
	int                     errors;
	int                     checks;

	rob_top u_rob_top (
		.clk            (clk),
		.rst            (rst),
		.dispatch_en_i  (dispatch_en_i),
		.dispatch_i     (dispatch_i),
		.complete_i     (complete_i),
		.complete_idx_i (complete_idx_i),
		.resolve_done_i (resolve_done_i),
		.resolve_i      (resolve_i),
		.npc_rd_idx_i   (npc_rd_idx_i),
		.tail_o         (tail_o),
		.stall_o        (stall_o),
		.retire_rdy_o   (retire_rdy_o),
		.retire_o       (retire_o),
		.halt_o         (halt_o),
		.recovery_o     (recovery_o),
		.recover_o      (recover_o),
		.br_right_o     (br_right_o),
		.npc_o          (npc_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//------------------------------------------------------------
	// helpers
	//------------------------------------------------------------
	task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic rob_pkg::rob_dispatch_t make_entry(input logic is_br, input logic is_halt);
		rob_pkg::rob_dispatch_t e;
		e             = '0;
		e.new_tag     = rob_pkg::prf_tag_t'($urandom_range(0, 63));
		e.old_tag     = rob_pkg::prf_tag_t'($urandom_range(0, 63));
		e.arch_dest   = rob_pkg::arch_reg_t'($urandom_range(0, 31));
		e.pc          = {$urandom, $urandom};
		e.pc[1:0]     = 2'b00;   // word aligned
		e.br_flag     = is_br;
		e.pred_taken  = is_br && $urandom_range(0, 1) == 1;
		e.pred_target = is_br ? {$urandom, $urandom} : '0;
		e.br_mask     = rob_pkg::br_mask_t'($urandom_range(0, 15));
		e.fl_head     = rob_pkg::fl_head_t'($urandom_range(0, 31));
		e.halt        = is_halt;
		return e;
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		rst            <= 1'b1;
		dispatch_en_i  <= 1'b0;
		complete_i     <= 1'b0;
		resolve_done_i <= 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		model_q.delete();
		ptr_q.delete();
		exp_tail = '0;
	endtask

	// writes one entry at the next edge and drops the strobe after it
	task automatic dispatch_one(input rob_pkg::rob_dispatch_t e);
		@(posedge clk);
		dispatch_en_i <= 1'b1;
		dispatch_i    <= e;
		model_q.push_back(e);
		ptr_q.push_back(exp_tail);
		exp_tail = exp_tail + 1'b1;
		@(posedge clk);
		dispatch_en_i <= 1'b0;
	endtask

	// samples once per cycle and checks retire against the model order
	task automatic sample_retire();
		rob_pkg::rob_dispatch_t e;
		@(negedge clk);
		if (!retire_rdy_o) begin
			check_equal("retire_o", retire_o, '0);
		end else if (model_q.size() == 0) begin
			errors++;
			$display("retire_rdy_o is high but no dispatched entry is left at %0t", $time);
		end else begin
			e = model_q.pop_front();
			ptr_q.delete(0);
			check_equal("retire_o.arch_tag", retire_o.arch_tag, e.new_tag);
			check_equal("retire_o.old_tag", retire_o.old_tag, e.old_tag);
			check_equal("retire_o.arch_dest", retire_o.arch_dest, e.arch_dest);
		end
	endtask

	task automatic complete_and_drain(input bit reverse);
		rob_pkg::rob_ptr_t order [$];
		int                n;
		int                cycles;
		order = ptr_q;
		n     = order.size();
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			complete_i     <= 1'b1;
			complete_idx_i <= reverse ? order[n-1-i] : order[i];
			sample_retire();
			if (reverse) begin
				check_equal("retire_rdy_o", retire_rdy_o, 1'b0);   // head still not done
			end
		end
		@(posedge clk);
		complete_i <= 1'b0;
		cycles = 0;
		while (model_q.size() != 0 && cycles < 3 * `ROB_DEPTH) begin
			sample_retire();
			cycles++;
		end
		if (model_q.size() != 0) begin
			errors++;
			$display("%0d completed entries never retired", model_q.size());
		end
	endtask

	//------------------------------------------------------------
	// tests
	//------------------------------------------------------------
	task automatic fill_until_stall();
		rob_pkg::rob_ptr_t start;
		start = exp_tail;
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			if (i == `ROB_DEPTH - 1) begin
				@(negedge clk);
				check_equal("stall_o", stall_o, 1'b0);   // one slot left
			end
			dispatch_one(make_entry(1'b0, 1'b0));
		end
		@(negedge clk);
		check_equal("stall_o", stall_o, 1'b1);
		check_equal("tail_o", tail_o, rob_pkg::rob_ptr_t'(start + `ROB_DEPTH));
	endtask

	task automatic retire_in_order();
		complete_and_drain(1'b1);
	endtask

	task automatic read_next_pc();
		int k;
		repeat (8) dispatch_one(make_entry(1'b0, 1'b0));
		repeat (4) begin
			k = $urandom_range(0, model_q.size() - 1);
			@(posedge clk);
			npc_rd_idx_i <= ptr_q[k];
			@(negedge clk);
			check_equal("npc_o", npc_o, model_q[k].pc + `ADDR_W'(`INSTR_BYTES));
		end
	endtask

	task automatic resolve_correct_branch();
		rob_pkg::rob_dispatch_t e;
		rob_pkg::rob_resolve_t  res;
		int                     k;
		e = make_entry(1'b1, 1'b0);
		dispatch_one(e);
		k = ptr_q.size() - 1;
		repeat (2) dispatch_one(make_entry(1'b0, 1'b0));   // a rollback would cut these off
		res.ptr    = ptr_q[k];
		res.taken  = e.pred_taken;
		res.target = e.pred_target;
		@(posedge clk);
		resolve_done_i <= 1'b1;
		resolve_i      <= res;
		@(negedge clk);
		check_equal("br_right_o", br_right_o, 1'b1);
		check_equal("recovery_o", recovery_o, 1'b0);
		@(posedge clk);
		resolve_done_i <= 1'b0;
		@(negedge clk);
		check_equal("tail_o", tail_o, exp_tail);
	endtask

	task automatic recover_mispredict();
		rob_pkg::rob_dispatch_t e;
		rob_pkg::rob_resolve_t  res;
		int                     k;
		e = make_entry(1'b1, 1'b0);
		dispatch_one(e);
		k = ptr_q.size() - 1;
		repeat (3) dispatch_one(make_entry(1'b0, 1'b0));   // younger entries that get squashed
		res.ptr    = ptr_q[k];
		res.taken  = ~e.pred_taken;
		res.target = e.pred_target;
		@(posedge clk);
		resolve_done_i <= 1'b1;
		resolve_i      <= res;
		@(negedge clk);
		check_equal("recovery_o", recovery_o, 1'b1);
		check_equal("br_right_o", br_right_o, 1'b0);
		check_equal("recover_o", recover_o, {e.br_mask, e.fl_head});
		@(posedge clk);   // rollback edge with resolve still held
		@(negedge clk);
		check_equal("tail_o", tail_o, rob_pkg::rob_ptr_t'(res.ptr + 1'b1));
		check_equal("recovery_o", recovery_o, 1'b0);
		@(posedge clk);
		resolve_done_i <= 1'b0;
		while (model_q.size() > k + 1) begin
			model_q.delete(model_q.size() - 1);
			ptr_q.delete(ptr_q.size() - 1);
		end
		exp_tail = res.ptr + 1'b1;
	endtask

	task automatic halt_at_head();
		apply_reset();
		@(negedge clk);
		check_equal("halt_o", halt_o, 1'b0);
		check_equal("tail_o", tail_o, '0);
		dispatch_one(make_entry(1'b0, 1'b1));
		@(negedge clk);
		check_equal("halt_o", halt_o, 1'b1);
		complete_and_drain(1'b0);
		@(posedge clk);   // last retire
		@(negedge clk);
		check_equal("halt_o", halt_o, 1'b0);
	endtask

	//------------------------------------------------------------
	// main sequence and watchdog
	//------------------------------------------------------------
	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		dispatch_en_i  = 1'b0;
		dispatch_i     = '0;
		complete_i     = 1'b0;
		complete_idx_i = '0;
		resolve_done_i = 1'b0;
		resolve_i      = '0;
		npc_rd_idx_i   = '0;
		exp_tail       = '0;
		errors         = 0;
		checks         = 0;
		void'($urandom(SEED));
		apply_reset();
		fill_until_stall();
		retire_in_order();
		read_next_pc();
		resolve_correct_branch();
		recover_mispredict();
		halt_at_head();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * 200 * NUM_TESTS);
		$display("timeout: the tests did not finish within %0d cycles", 200 * NUM_TESTS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* rob.f */
+incdir+design
design/rob_pkg.sv
design/rob_ptr_ctrl.sv
design/rob_entry_store.sv
design/rob_branch_check.sv
design/rob_retire.sv
design/rob_top.sv
tb/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module rob_tb -f rob.f -o rob_sim

./obj_dir/rob_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
